/* Bender.yml */
package:
  name: ahb_sram

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/ahb_pkg.sv
      - src/sram_pkg.sv
      - src/ahb_phase_ctrl.sv
      - src/raw_bypass.sv
      - src/sram_byte_bank.sv
      - src/ahb_resp_unit.sv
      - src/ahb_sram_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_ahb_sram.sv

/* include/ahb_sram_defs.svh */
//==========================================================================
// bus and sram width macros, lane organisation of the 128-bit bank
//==========================================================================

`ifndef AHB_SRAM_DEFS_SVH
`define AHB_SRAM_DEFS_SVH

// bus side
`define AHB_DATA_W    128
`define SRAM_ADDR_W   17     // byte address inside the sram window

// sram organisation
`define LANE_W        8      // one byte per lane
`define SRAM_LANES    16
`define LANE_SEL_W    4      // log2 of the lane count

// word address of a single lane
`define BANK_DEPTH_W  (`SRAM_ADDR_W - `LANE_SEL_W)

`endif

/* list.f */
+incdir+include
src/ahb_pkg.sv
src/sram_pkg.sv
src/ahb_phase_ctrl.sv
src/raw_bypass.sv
src/sram_byte_bank.sv
src/ahb_resp_unit.sv
src/ahb_sram_top.sv
tests/tb_ahb_sram.sv

/* src/ahb_phase_ctrl.sv */
//==========================================================================
// address phase capture, lane write-enable decode and ram address select
//==========================================================================

`include "ahb_sram_defs.svh"

module ahb_phase_ctrl
    import ahb_pkg::*, sram_pkg::*;
(
    input  logic                    hclk,
    input  logic                    hrst_b,
    input  logic                    hsel,
    input  htrans_e                 htrans,
    input  hsize_e                  hsize,
    input  logic [`SRAM_ADDR_W-1:0] haddr,
    input  logic                    hwrite,
    input  logic [`AHB_DATA_W-1:0]  hwdata,
    input  logic                    hready,
    input  logic                    stall_req,
    output bank_req_t               bank_req,
    output ahb_phase_t              cur_phase,
    output ahb_phase_t              pend_phase
);

    logic                    trans_valid;
    logic                    replay_q;      // data phase of a stalled read
    lane_mask_t              lane_mask_q;
    logic [`SRAM_ADDR_W-1:0] ram_addr;

    // lanes touched by one transfer of the given size at the given lane offset
    function automatic lane_mask_t lane_decode(
        input hsize_e                 size,
        input logic [`LANE_SEL_W-1:0] low
    );
        lane_mask_t             span;
        logic [`LANE_SEL_W-1:0] lsb;

        span = ~({`SRAM_LANES{1'b1}} << (1 << size));   // 2**size lanes
        lsb  = ~({`LANE_SEL_W{1'b1}} << size);          // offset bits below alignment
        if (size > HSIZE_QWORD)
            return '0;
        return span << (low & ~lsb);
    endfunction

    assign trans_valid = hsel && hready
                      && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);

    always_comb begin
        cur_phase.write = trans_valid && hwrite;
        cur_phase.read  = trans_valid && !hwrite;
        cur_phase.size  = hsize;
        cur_phase.addr  = haddr;
    end

    always_ff @(posedge hclk or negedge hrst_b) begin
        if (!hrst_b) begin
            pend_phase  <= '0;
            lane_mask_q <= '0;
            replay_q    <= 1'b0;
        end else begin
            replay_q <= stall_req;
            if (cur_phase.write)
                lane_mask_q <= lane_decode(hsize, haddr[`LANE_SEL_W-1:0]);
            else
                lane_mask_q <= '0;
            if (trans_valid)
                pend_phase <= cur_phase;
            else if (hready)
                pend_phase <= '0;   // idle, busy or deselected
        end
    end

    // captured address while the write lands or the read is replayed
    assign ram_addr = (pend_phase.write || replay_q) ? pend_phase.addr : haddr;

    assign bank_req = '{
        addr:  ram_addr[`SRAM_ADDR_W-1:`LANE_SEL_W],
        wen:   lane_mask_q,
        wdata: hwdata
    };

    // byte enables only in a zero wait write data phase
    a_mask_in_write_phase: assert property (
        @(posedge hclk) disable iff (!hrst_b)
        (|lane_mask_q) |-> pend_phase.write && hready
    );

    // a replayed read never shares its cycle with a write
    a_replay_no_write: assert property (
        @(posedge hclk) disable iff (!hrst_b)
        replay_q |-> pend_phase.read && !hready
    );

endmodule

/* src/ahb_pkg.sv */
//==========================================================================
// AHB-Lite transfer kind and size encodings, captured address phase
//==========================================================================

`include "ahb_sram_defs.svh"

package ahb_pkg;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        HSIZE_BYTE  = 3'b000,
        HSIZE_HWORD = 3'b001,
        HSIZE_WORD  = 3'b010,
        HSIZE_DWORD = 3'b011,
        HSIZE_QWORD = 3'b100     // full bus beat
    } hsize_e;

    // one accepted address phase
    typedef struct packed {
        logic                    write;
        logic                    read;
        hsize_e                  size;
        logic [`SRAM_ADDR_W-1:0] addr;
    } ahb_phase_t;

endpackage

/* src/ahb_resp_unit.sv */
//==========================================================================
// hready wait state register and read data select
//==========================================================================

`include "ahb_sram_defs.svh"

module ahb_resp_unit (
    input  logic                   hclk,
    input  logic                   hrst_b,
    input  logic                   stall_req,
    input  logic                   fwd_valid,
    input  logic [`AHB_DATA_W-1:0] fwd_data,
    input  logic [`AHB_DATA_W-1:0] bank_rdata,
    output logic                   hready,
    output logic [`AHB_DATA_W-1:0] hrdata
);

    // low in reset and for one wait state per unresolved hazard
    always_ff @(posedge hclk or negedge hrst_b) begin
        if (!hrst_b)
            hready <= 1'b0;
        else
            hready <= !stall_req;
    end

    assign hrdata = fwd_valid ? fwd_data : bank_rdata;

    // the replay always completes on the next cycle
    a_single_wait: assert property (
        @(posedge hclk) disable iff (!hrst_b)
        (!hready && $past(hrst_b)) |=> hready
    );

    // forwarded data only in a zero wait data phase
    a_fwd_ready: assert property (
        @(posedge hclk) disable iff (!hrst_b)
        fwd_valid |-> hready
    );

endmodule

/* src/ahb_sram_top.sv */
//==========================================================================
// AHB-Lite slave with a 128-bit byte-lane sram
//==========================================================================

`include "ahb_sram_defs.svh"

module ahb_sram_top
    import ahb_pkg::*, sram_pkg::*;
(
    input  logic                    hclk,
    input  logic                    hrst_b,
    input  logic                    hsel,
    input  htrans_e                 htrans,
    input  hsize_e                  hsize,
    input  logic [`SRAM_ADDR_W-1:0] haddr,
    input  logic                    hwrite,
    input  logic [`AHB_DATA_W-1:0]  hwdata,
    output logic [`AHB_DATA_W-1:0]  hrdata,
    output logic                    hready,
    output logic                    hresp
);

    bank_req_t              bank_req;
    ahb_phase_t             cur_phase;
    ahb_phase_t             pend_phase;
    logic                   stall_req;
    logic                   fwd_valid;
    logic [`AHB_DATA_W-1:0] fwd_data;
    logic [`AHB_DATA_W-1:0] bank_rdata;

    assign hresp = 1'b0;   // always okay

    ahb_phase_ctrl ahb_phase_ctrl_inst (
        .hclk       (hclk),
        .hrst_b     (hrst_b),
        .hsel       (hsel),
        .htrans     (htrans),
        .hsize      (hsize),
        .haddr      (haddr),
        .hwrite     (hwrite),
        .hwdata     (hwdata),
        .hready     (hready),
        .stall_req  (stall_req),
        .bank_req   (bank_req),
        .cur_phase  (cur_phase),
        .pend_phase (pend_phase)
    );

    raw_bypass raw_bypass_inst (
        .hclk       (hclk),
        .hrst_b     (hrst_b),
        .cur_phase  (cur_phase),
        .pend_phase (pend_phase),
        .hwdata     (hwdata),
        .stall_req  (stall_req),
        .fwd_valid  (fwd_valid),
        .fwd_data   (fwd_data)
    );

    sram_byte_bank sram_byte_bank_inst (
        .hclk       (hclk),
        .bank_req   (bank_req),
        .bank_rdata (bank_rdata)
    );

    ahb_resp_unit ahb_resp_unit_inst (
        .hclk       (hclk),
        .hrst_b     (hrst_b),
        .stall_req  (stall_req),
        .fwd_valid  (fwd_valid),
        .fwd_data   (fwd_data),
        .bank_rdata (bank_rdata),
        .hready     (hready),
        .hrdata     (hrdata)
    );

endmodule

/* src/raw_bypass.sv */
//==========================================================================
// read-after-write hazard check, forwarding register and stall request
//==========================================================================

`include "ahb_sram_defs.svh"

module raw_bypass
    import ahb_pkg::*;
(
    input  logic                   hclk,
    input  logic                   hrst_b,
    input  ahb_phase_t             cur_phase,
    input  ahb_phase_t             pend_phase,
    input  logic [`AHB_DATA_W-1:0] hwdata,
    output logic                   stall_req,
    output logic                   fwd_valid,
    output logic [`AHB_DATA_W-1:0] fwd_data
);

    logic                    hazard;
    logic                    covered;
    logic                    fwd_hit;
    logic [`SRAM_ADDR_W-1:0] unit_mask;   // address bits above the write alignment

    // read address phase against a write data phase
    assign hazard = pend_phase.write && cur_phase.read;

    // read no wider than the write and inside the same write-sized unit
    assign unit_mask = {`SRAM_ADDR_W{1'b1}} << pend_phase.size;
    assign covered   = (cur_phase.size <= pend_phase.size)
                    && (((cur_phase.addr ^ pend_phase.addr) & unit_mask) == '0);

    assign fwd_hit   = hazard && covered;
    assign stall_req = hazard && !covered;   // ram cannot serve both this cycle

    always_ff @(posedge hclk or negedge hrst_b) begin
        if (!hrst_b)
            fwd_valid <= 1'b0;
        else
            fwd_valid <= fwd_hit;
    end

    // whole write beat, the read lanes are a subset of it
    always_ff @(posedge hclk) begin
        if (fwd_hit)
            fwd_data <= hwdata;
    end

    // a stalled hazard is neither forwarded nor stalled again
    a_stall_not_fwd: assert property (
        @(posedge hclk) disable iff (!hrst_b)
        stall_req |=> !(fwd_valid || stall_req)
    );

endmodule

/* src/sram_byte_bank.sv */
//==========================================================================
// sixteen byte-wide synchronous ram lanes sharing one word address
//==========================================================================

`include "ahb_sram_defs.svh"

module sram_byte_bank
    import sram_pkg::*;
(
    input  logic                   hclk,
    input  bank_req_t              bank_req,
    output logic [`AHB_DATA_W-1:0] bank_rdata
);

    localparam int DEPTH = 1 << `BANK_DEPTH_W;

    for (genvar i = 0; i < `SRAM_LANES; i++) begin : g_lane
        logic [`LANE_W-1:0] mem [DEPTH];
        logic [`LANE_W-1:0] rd_q;

        always_ff @(posedge hclk) begin
            if (bank_req.wen[i])
                mem[bank_req.addr] <= bank_req.wdata[i*`LANE_W +: `LANE_W];
            rd_q <= mem[bank_req.addr];   // old byte on a write cycle
        end

        assign bank_rdata[i*`LANE_W +: `LANE_W] = rd_q;
    end

endmodule

/* src/sram_pkg.sv */
//==========================================================================
// byte lane write mask and sram bank request types
//==========================================================================

`include "ahb_sram_defs.svh"

package sram_pkg;

    // bit i enables byte lane i
    typedef logic [`SRAM_LANES-1:0] lane_mask_t;

    // one access to all lanes at a common word address
    typedef struct packed {
        logic [`BANK_DEPTH_W-1:0] addr;
        lane_mask_t               wen;
        logic [`AHB_DATA_W-1:0]   wdata;   // lane i takes byte i
    } bank_req_t;

endpackage

/* tests/tb_ahb_sram.sv */
//==========================================================================
// testbench for the AHB-Lite sram slave: bus driver, reference memory,
// protocol and read data assertions, watchdog
//==========================================================================

`include "ahb_sram_defs.svh"

module tb_ahb_sram
    import ahb_pkg::*;
();

    localparam int RESET_CYCLES    = 10;
    localparam int N_FILL          = 64;   // quadword units in the test window
    localparam int N_PER_SIZE      = 4;
    localparam int N_HAZARD        = 24;
    localparam int N_RAND          = 300;
    localparam int WIN_BYTES       = N_FILL * `SRAM_LANES;
    localparam int N_XFERS         = N_FILL + 2 + 5 * (2 * N_PER_SIZE + 4) + 4 * 3
                                   + 2 * 3 * N_HAZARD + 4 * 4 + N_RAND + 2;
    localparam int WATCHDOG_CYCLES = 3 * N_XFERS + RESET_CYCLES + 50;

    logic                    hclk;
    logic                    hrst_b;
    logic                    hsel;
    htrans_e                 htrans;
    hsize_e                  hsize;
    logic [`SRAM_ADDR_W-1:0] haddr;
    logic                    hwrite;
    logic [`AHB_DATA_W-1:0]  hwdata;
    logic [`AHB_DATA_W-1:0]  hrdata;
    logic                    hready;
    logic                    hresp;

    logic [`LANE_W-1:0]      ref_mem [0:(1 << `SRAM_ADDR_W)-1];
    logic                    bus_valid;
    logic                    dp_write;        // data phase in progress
    logic                    dp_read;
    hsize_e                  dp_size;
    logic [`SRAM_ADDR_W-1:0] dp_addr;
    logic [`AHB_DATA_W-1:0]  exp_data;
    logic [`AHB_DATA_W-1:0]  exp_mask;
    logic [`AHB_DATA_W-1:0]  ld_data;
    logic [`AHB_DATA_W-1:0]  ld_mask;
    logic                    raw_covered;     // read right after a write
    logic                    raw_uncovered;
    logic [`SRAM_ADDR_W-1:0] win_base;
    logic [`AHB_DATA_W-1:0]  next_wdata;

    ahb_sram_top ahb_sram_top_inst (
        .hclk   (hclk),
        .hrst_b (hrst_b),
        .hsel   (hsel),
        .htrans (htrans),
        .hsize  (hsize),
        .haddr  (haddr),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hready (hready),
        .hresp  (hresp)
    );

    initial begin
        hclk = 1'b0;
        forever #5 hclk = ~hclk;
    end

    task automatic stop_failed();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [`AHB_DATA_W-1:0] exp,
                                   input logic [`AHB_DATA_W-1:0] got);
        $display("error %s exp %h got %h", name, exp, got);
        stop_failed();
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        stop_failed();
    endtask

    function automatic logic [`SRAM_ADDR_W-1:0] align_addr(
        input logic [`SRAM_ADDR_W-1:0] addr,
        input hsize_e                  size
    );
        return (addr >> size) << size;
    endfunction

    // read inside the write unit and no wider than the write
    function automatic logic covers(
        input logic [`SRAM_ADDR_W-1:0] w_addr,
        input hsize_e                  w_size,
        input logic [`SRAM_ADDR_W-1:0] r_addr,
        input hsize_e                  r_size
    );
        return (r_size <= w_size) && ((r_addr >> w_size) == (w_addr >> w_size));
    endfunction

    function automatic logic [`AHB_DATA_W-1:0] rand_data();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic logic [`SRAM_ADDR_W-1:0] rand_addr(input hsize_e size);
        return align_addr(win_base + `SRAM_ADDR_W'($urandom % WIN_BYTES), size);
    endfunction

    function automatic htrans_e pick_trans();
        return ($urandom % 2) ? HTRANS_SEQ : HTRANS_NONSEQ;
    endfunction

    task automatic ref_store(
        input logic [`SRAM_ADDR_W-1:0] addr,
        input hsize_e                  size,
        input logic [`AHB_DATA_W-1:0]  data
    );
        logic [`SRAM_ADDR_W-1:0] base;
        int                      lane;
        base = align_addr(addr, size);
        for (int b = 0; b < (1 << size); b++) begin
            lane = (base + b) % `SRAM_LANES;
            ref_mem[base + b] = data[lane*`LANE_W +: `LANE_W];
        end
    endtask

    task automatic ref_load(
        input  logic [`SRAM_ADDR_W-1:0] addr,
        input  hsize_e                  size,
        output logic [`AHB_DATA_W-1:0]  data,
        output logic [`AHB_DATA_W-1:0]  mask
    );
        logic [`SRAM_ADDR_W-1:0] base;
        int                      lane;
        base = align_addr(addr, size);
        data = '0;
        mask = '0;
        for (int b = 0; b < (1 << size); b++) begin
            lane = (base + b) % `SRAM_LANES;
            data[lane*`LANE_W +: `LANE_W] = ref_mem[base + b];
            mask[lane*`LANE_W +: `LANE_W] = '1;
        end
    endtask

    assign bus_valid = hsel && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);

    // bus monitor, follows address and data phases from the AHB signals
    always @(posedge hclk or negedge hrst_b) begin
        if (!hrst_b) begin
            dp_write      <= 1'b0;
            dp_read       <= 1'b0;
            dp_size       <= HSIZE_BYTE;
            dp_addr       <= '0;
            exp_data      <= '0;
            exp_mask      <= '0;
            raw_covered   <= 1'b0;
            raw_uncovered <= 1'b0;
        end else if (hready) begin
            if (dp_write)
                ref_store(dp_addr, dp_size, hwdata);
            if (bus_valid && !hwrite) begin
                ref_load(haddr, hsize, ld_data, ld_mask);
                exp_data <= ld_data;
                exp_mask <= ld_mask;
            end
            raw_covered   <= dp_write && bus_valid && !hwrite
                          && covers(dp_addr, dp_size, haddr, hsize);
            raw_uncovered <= dp_write && bus_valid && !hwrite
                          && !covers(dp_addr, dp_size, haddr, hsize);
            dp_write <= bus_valid && hwrite;
            dp_read  <= bus_valid && !hwrite;
            dp_size  <= hsize;
            dp_addr  <= haddr;
        end else begin
            raw_covered   <= 1'b0;   // wait state
            raw_uncovered <= 1'b0;
        end
    end

    a_hresp_okay: assert property (@(posedge hclk) hresp == 1'b0)
        else report_mismatch("hresp", '0, $sampled(hresp));

    a_reset_wait: assert property (@(posedge hclk) !hrst_b |=> !hready)
        else report_problem("hready was high during reset");

    a_ready_after_reset: assert property (@(posedge hclk) $rose(hrst_b) |=> hready)
        else report_problem("hready did not rise on the first edge after reset");

    a_read_data: assert property (@(posedge hclk) disable iff (!hrst_b)
        (dp_read && hready) |-> (hrdata & exp_mask) == (exp_data & exp_mask))
        else report_mismatch("hrdata", $sampled(exp_data & exp_mask),
                             $sampled(hrdata & exp_mask));

    a_covered_no_wait: assert property (@(posedge hclk) disable iff (!hrst_b)
        raw_covered |-> hready)
        else report_problem("hready dropped on a read covered by the previous write");

    a_uncovered_one_wait: assert property (@(posedge hclk) disable iff (!hrst_b)
        raw_uncovered |-> !hready ##1 hready)
        else report_problem("hready did not drop for exactly one cycle on an uncovered read");

    a_wait_only_on_hazard: assert property (@(posedge hclk) disable iff (!hrst_b)
        (!hready && $past(hrst_b)) |-> raw_uncovered)
        else report_problem("hready dropped without a read after write hazard");

    // drives one address phase plus the data of the previous one
    task automatic bus_xfer(
        input logic                    sel,
        input htrans_e                 tr,
        input logic                    wr,
        input hsize_e                  size,
        input logic [`SRAM_ADDR_W-1:0] addr,
        input logic [`AHB_DATA_W-1:0]  wdata
    );
        logic rdy;
        hsel   <= sel;
        htrans <= tr;
        hwrite <= wr;
        hsize  <= size;
        haddr  <= addr;
        hwdata <= next_wdata;
        if (sel && wr && (tr == HTRANS_NONSEQ || tr == HTRANS_SEQ))
            next_wdata = wdata;
        else
            next_wdata = rand_data();   // junk, must not land
        do begin
            @(negedge hclk);
            rdy = hready;
            @(posedge hclk);
        end while (!rdy);
    endtask

    task automatic write_xfer(input hsize_e size, input logic [`SRAM_ADDR_W-1:0] addr);
        bus_xfer(1'b1, pick_trans(), 1'b1, size, addr, rand_data());
    endtask

    task automatic read_xfer(input hsize_e size, input logic [`SRAM_ADDR_W-1:0] addr);
        bus_xfer(1'b1, pick_trans(), 1'b0, size, addr, '0);
    endtask

    task automatic idle_xfer(input int n);
        repeat (n) bus_xfer(1'b1, HTRANS_IDLE, 1'b0, HSIZE_BYTE, '0, '0);
    endtask

    initial begin
        logic [`SRAM_ADDR_W-1:0] addrs [N_PER_SIZE];
        logic [`SRAM_ADDR_W-1:0] a;
        hsize_e                  ws;
        hsize_e                  rs;

        void'($urandom(32'hd63));
        hrst_b     = 1'b0;
        hsel       = 1'b0;
        htrans     = HTRANS_IDLE;
        hsize      = HSIZE_BYTE;
        haddr      = '0;
        hwrite     = 1'b0;
        hwdata     = '0;
        next_wdata = '0;
        win_base   = `SRAM_ADDR_W'(($urandom % ((1 << `SRAM_ADDR_W) / WIN_BYTES)) * WIN_BYTES);
        repeat (RESET_CYCLES) @(posedge hclk);
        hrst_b <= 1'b1;

        for (int i = 0; i < N_FILL; i++)
            write_xfer(HSIZE_QWORD, win_base + `SRAM_ADDR_W'(i * `SRAM_LANES));
        idle_xfer(2);

        // each size, read back after a gap
        for (int s = 0; s < 5; s++) begin
            for (int i = 0; i < N_PER_SIZE; i++) begin
                addrs[i] = rand_addr(hsize_e'(s));
                write_xfer(hsize_e'(s), addrs[i]);
            end
            idle_xfer(3);
            for (int i = 0; i < N_PER_SIZE; i++)
                read_xfer(hsize_e'(s), addrs[i]);
            idle_xfer(1);
        end

        // narrow write inside an old quadword
        for (int s = 0; s < 4; s++) begin
            a = rand_addr(hsize_e'(s));
            write_xfer(hsize_e'(s), a);
            idle_xfer(1);
            read_xfer(HSIZE_QWORD, align_addr(a, HSIZE_QWORD));
        end

        // covered read straight after the write, forwarded
        for (int i = 0; i < N_HAZARD; i++) begin
            ws = hsize_e'($urandom % 5);
            rs = hsize_e'($urandom % (ws + 1));
            a  = rand_addr(ws);
            write_xfer(ws, a);
            read_xfer(rs, align_addr(a + `SRAM_ADDR_W'($urandom % (1 << ws)), rs));
            if (i % 3 == 0)
                idle_xfer(1);
        end

        // uncovered read, wider or in another unit
        for (int i = 0; i < N_HAZARD; i++) begin
            ws = hsize_e'($urandom % 5);
            a  = rand_addr(ws);
            write_xfer(ws, a);
            if (ws != HSIZE_QWORD && ($urandom % 2) == 1) begin
                rs = hsize_e'(ws + 1 + $urandom % (4 - ws));
                read_xfer(rs, align_addr(a, rs));
            end else begin
                read_xfer(ws, a ^ (`SRAM_ADDR_W'(1) << ws));
            end
            if (($urandom % 2) == 1)
                idle_xfer(1);
        end

        // deselected and idle writes leave memory alone
        for (int i = 0; i < 4; i++) begin
            a = rand_addr(HSIZE_QWORD);
            bus_xfer(1'b0, HTRANS_NONSEQ, 1'b1, HSIZE_QWORD, a, rand_data());
            bus_xfer(1'b1, HTRANS_IDLE, 1'b1, HSIZE_QWORD, a, rand_data());
            idle_xfer(1);
            read_xfer(HSIZE_QWORD, a);
        end

        for (int i = 0; i < N_RAND; i++) begin
            ws = hsize_e'($urandom % 5);
            a  = rand_addr(ws);
            case ($urandom % 4)
                0, 1:    write_xfer(ws, a);
                2:       read_xfer(ws, a);
                default: idle_xfer(1);
            endcase
        end
        idle_xfer(2);

        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge hclk);
        report_problem("watchdog expired before the test sequence finished");
    end

endmodule
